// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // rv32i major opcodes in scope
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_BLTU = 3'd5,
        BR_BGEU = 3'd6
    } br_func_t;

    // next pc kind, resolved in execute
    typedef enum logic [1:0] {
        PC_INC = 2'd0,
        PC_BR  = 2'd1,
        PC_JAL = 2'd2
    } pc_source_t;

endpackage

// ==== src/ex_pipe_pkg.sv ====
package ex_pipe_pkg;

    // operand source chosen by the hazard unit
    typedef enum logic [1:0] {
        FWD_MEM = 2'b00,
        FWD_WB  = 2'b01,
        FWD_REG = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic                   valid;
        logic                   alu_imm;
        logic                   alu_pc;
        logic                   jal_rs1;
        logic                   illegal;
        rv_isa_pkg::alu_ctrl_t  alu_ctrl;
        rv_isa_pkg::br_func_t   br_func;
        rv_isa_pkg::pc_source_t pc_source;
        logic [4:0]             rd;
        logic                   is_store;
        logic                   writes_rd;
        logic [31:0]            pc;
        logic [31:0]            imm;
        logic [31:0]            rs1_data;
        logic [31:0]            rs2_data;
    } id_ex_t;

    // results handed on to the memory stage
    typedef struct packed {
        logic        valid;
        logic        take_branch;
        logic        is_store;
        logic        writes_rd;
        logic [4:0]  rd;
        logic [31:0] alu_out;
        logic [31:0] mem_data;
        logic [31:0] pc_inc;
        logic [31:0] target;
    } ex_mem_t;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]      alu_op1,
    input  logic [XLEN-1:0]      alu_op2,
    input  rv_isa_pkg::alu_ctrl_t alu_ctrl,
    output logic [XLEN-1:0]      alu_result
);

    logic [4:0] shamt;

    // rv32i shifts use only the low five bits
    assign shamt = alu_op2[4:0];

    always_comb begin
        case (alu_ctrl)
            rv_isa_pkg::ADD:    alu_result = alu_op1 + alu_op2;
            rv_isa_pkg::SUB:    alu_result = alu_op1 - alu_op2;
            rv_isa_pkg::SLL:    alu_result = alu_op1 << shamt;
            rv_isa_pkg::SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(alu_op1) < $signed(alu_op2)};
            rv_isa_pkg::SLTU:   alu_result = {{(XLEN-1){1'b0}}, alu_op1 < alu_op2};
            rv_isa_pkg::XOR:    alu_result = alu_op1 ^ alu_op2;
            rv_isa_pkg::SRL:    alu_result = alu_op1 >> shamt;
            rv_isa_pkg::SRA:    alu_result = $unsigned($signed(alu_op1) >>> shamt);
            rv_isa_pkg::OR:     alu_result = alu_op1 | alu_op2;
            rv_isa_pkg::AND:    alu_result = alu_op1 & alu_op2;
            rv_isa_pkg::PASS_B: alu_result = alu_op2;
            default:            alu_result = '0;
        endcase
    end

endmodule

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // flush beats stall; a cleared payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

    hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        (stall && !flush) |=> $stable(q)
    ) else $error("stage register changed while stalled");

endmodule

// ==== src/id_decode.sv ====
`timescale 1ns/1ps

module id_decode #(
    parameter int XLEN = 32
) (
    input  logic                in_valid,
    input  logic [31:0]         instr,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     rs2_data,
    output ex_pipe_pkg::id_ex_t dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        known;
    logic        writes;
    logic        store;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // alt selects sub / sra
    function automatic rv_isa_pkg::alu_ctrl_t alu_op_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            3'b001:  return rv_isa_pkg::SLL;
            3'b010:  return rv_isa_pkg::SLT;
            3'b011:  return rv_isa_pkg::SLTU;
            3'b100:  return rv_isa_pkg::XOR;
            3'b101:  return alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
            3'b110:  return rv_isa_pkg::OR;
            default: return rv_isa_pkg::AND;
        endcase
    endfunction

    always_comb begin
        dec = '0;
        known = 1'b1;
        writes = 1'b0;
        store = 1'b0;
        dec.alu_ctrl = rv_isa_pkg::ADD;
        dec.br_func = rv_isa_pkg::BR_NONE;
        dec.pc_source = rv_isa_pkg::PC_INC;

        case (opcode)
            rv_isa_pkg::OP: begin
                writes = 1'b1;
                dec.alu_ctrl = alu_op_of(funct3, funct7[5]);
                known = (funct7 == 7'h00) ||
                        (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_isa_pkg::OP_IMM: begin
                writes = 1'b1;
                dec.alu_imm = 1'b1;
                dec.imm = imm_i;
                dec.alu_ctrl = alu_op_of(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) begin
                    known = (funct7 == 7'h00);
                end else if (funct3 == 3'b101) begin
                    known = (funct7 == 7'h00) || (funct7 == 7'h20);
                end
            end
            rv_isa_pkg::LUI: begin
                writes = 1'b1;
                dec.alu_imm = 1'b1;
                dec.imm = imm_u;
                dec.alu_ctrl = rv_isa_pkg::PASS_B;
            end
            rv_isa_pkg::AUIPC: begin
                writes = 1'b1;
                dec.alu_pc = 1'b1;
                dec.alu_imm = 1'b1;
                dec.imm = imm_u;
            end
            rv_isa_pkg::JAL: begin
                writes = 1'b1;
                dec.imm = imm_j;
                dec.pc_source = rv_isa_pkg::PC_JAL;
            end
            rv_isa_pkg::JALR: begin
                writes = 1'b1;
                dec.imm = imm_i;
                dec.jal_rs1 = 1'b1;
                dec.pc_source = rv_isa_pkg::PC_JAL;
                known = (funct3 == 3'b000);
            end
            rv_isa_pkg::BRANCH: begin
                dec.imm = imm_b;
                dec.pc_source = rv_isa_pkg::PC_BR;
                case (funct3)
                    3'b000:  dec.br_func = rv_isa_pkg::BR_BEQ;
                    3'b001:  dec.br_func = rv_isa_pkg::BR_BNE;
                    3'b100:  dec.br_func = rv_isa_pkg::BR_BLT;
                    3'b101:  dec.br_func = rv_isa_pkg::BR_BGE;
                    3'b110:  dec.br_func = rv_isa_pkg::BR_BLTU;
                    3'b111:  dec.br_func = rv_isa_pkg::BR_BGEU;
                    default: known = 1'b0;
                endcase
            end
            rv_isa_pkg::LOAD: begin
                writes = 1'b1;
                dec.alu_imm = 1'b1;
                dec.imm = imm_i;
                known = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
            end
            rv_isa_pkg::STORE: begin
                store = 1'b1;
                dec.alu_imm = 1'b1;
                dec.imm = imm_s;
                known = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
            end
            default: known = 1'b0;
        endcase

        dec.valid = in_valid & known;
        dec.illegal = in_valid & ~known;
        dec.writes_rd = writes & dec.valid;
        dec.is_store = store & dec.valid;
        dec.rd = writes ? instr[11:7] : 5'd0;
        dec.pc = pc;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;

        if (dec.valid) begin
            assert (!dec.illegal)
                else $error("decoder emitted a valid packet marked illegal");
        end
    end

endmodule

// ==== src/execute.sv ====
`timescale 1ns/1ps

module execute #(
    parameter int XLEN = 32
) (
    input  ex_pipe_pkg::id_ex_t   ex,
    input  ex_pipe_pkg::fwd_sel_t fwd_rs1,
    input  ex_pipe_pkg::fwd_sel_t fwd_rs2,
    input  logic [XLEN-1:0]       m_data,
    input  logic [XLEN-1:0]       w_data,
    output ex_pipe_pkg::ex_mem_t  res
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] alu_op1;
    logic [XLEN-1:0] alu_op2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] pc_inc;
    logic [XLEN-1:0] br_addr;
    logic [XLEN-1:0] jump_addr;
    logic [XLEN-1:0] redirect;
    logic            br_cond;
    logic            take_branch;

    // operand forwarding
    always_comb begin
        case (fwd_rs1)
            ex_pipe_pkg::FWD_MEM: rs1_val = m_data;
            ex_pipe_pkg::FWD_WB:  rs1_val = w_data;
            default:              rs1_val = ex.rs1_data;
        endcase
    end

    always_comb begin
        case (fwd_rs2)
            ex_pipe_pkg::FWD_MEM: rs2_val = m_data;
            ex_pipe_pkg::FWD_WB:  rs2_val = w_data;
            default:              rs2_val = ex.rs2_data;
        endcase
    end

    assign alu_op1 = ex.alu_pc ? ex.pc : rs1_val;
    assign alu_op2 = ex.alu_imm ? ex.imm : rs2_val;

    alu #(
        .XLEN (XLEN)
    ) u_alu (
        .alu_op1    (alu_op1),
        .alu_op2    (alu_op2),
        .alu_ctrl   (ex.alu_ctrl),
        .alu_result (alu_result)
    );

    always_comb begin
        case (ex.br_func)
            rv_isa_pkg::BR_BEQ:  br_cond = (rs1_val == rs2_val);
            rv_isa_pkg::BR_BNE:  br_cond = (rs1_val != rs2_val);
            rv_isa_pkg::BR_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            rv_isa_pkg::BR_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            rv_isa_pkg::BR_BLTU: br_cond = (rs1_val < rs2_val);
            rv_isa_pkg::BR_BGEU: br_cond = (rs1_val >= rs2_val);
            default:             br_cond = 1'b0;
        endcase
    end

    assign pc_inc = ex.pc + 4;
    assign br_addr = ex.pc + ex.imm;
    // jalr uses rs1 as base
    assign jump_addr = (ex.jal_rs1 ? rs1_val : ex.pc) + ex.imm;

    always_comb begin
        case (ex.pc_source)
            rv_isa_pkg::PC_BR: begin
                take_branch = br_cond;
                redirect = br_addr;
            end
            rv_isa_pkg::PC_JAL: begin
                take_branch = 1'b1;
                redirect = {jump_addr[XLEN-1:1], 1'b0};
            end
            default: begin
                take_branch = 1'b0;
                redirect = '0;
            end
        endcase
    end

    always_comb begin
        res.valid = ex.valid;
        res.take_branch = ex.valid & take_branch;
        res.is_store = ex.valid & ex.is_store;
        res.writes_rd = ex.valid & ex.writes_rd;
        res.rd = ex.rd;
        res.alu_out = (ex.pc_source == rv_isa_pkg::PC_JAL) ? pc_inc : alu_result;
        res.mem_data = rs2_val;
        res.pc_inc = pc_inc;
        res.target = res.take_branch ? redirect : '0;

        if (ex.valid && ex.pc_source == rv_isa_pkg::PC_JAL) begin
            assert (res.take_branch)
                else $error("decoded jump did not redirect");
        end
    end

endmodule

// ==== src/ex_subsystem.sv ====
`timescale 1ns/1ps

module ex_subsystem #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:0]           instr,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       rs1_data,
    input  logic [XLEN-1:0]       rs2_data,
    input  logic                  stall,
    input  logic                  flush,
    input  ex_pipe_pkg::fwd_sel_t fwd_rs1,
    input  ex_pipe_pkg::fwd_sel_t fwd_rs2,
    input  logic [XLEN-1:0]       m_data,
    input  logic [XLEN-1:0]       w_data,
    output ex_pipe_pkg::ex_mem_t  result
);

    ex_pipe_pkg::id_ex_t  dec;
    ex_pipe_pkg::id_ex_t  ex_pkt;
    ex_pipe_pkg::ex_mem_t ex_res;

    id_decode #(
        .XLEN (XLEN)
    ) u_id_decode (
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec)
    );

    pipe_reg #(
        .payload_t (ex_pipe_pkg::id_ex_t)
    ) u_id_ex (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .d     (dec),
        .q     (ex_pkt)
    );

    execute #(
        .XLEN (XLEN)
    ) u_execute (
        .ex      (ex_pkt),
        .fwd_rs1 (fwd_rs1),
        .fwd_rs2 (fwd_rs2),
        .m_data  (m_data),
        .w_data  (w_data),
        .res     (ex_res)
    );

    // flush only squashes the instruction entering EX
    pipe_reg #(
        .payload_t (ex_pipe_pkg::ex_mem_t)
    ) u_ex_mem (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (1'b0),
        .d     (ex_res),
        .q     (result)
    );

endmodule

// ==== tb/ex_subsystem_tb.sv ====
`timescale 1ns/1ps

module ex_subsystem_tb;

    localparam int XLEN = 32;

    // one line of the test file, minus name and expected result
    typedef struct packed {
        logic [31:0]           instr;
        logic [31:0]           pc;
        logic [31:0]           rs1;
        logic [31:0]           rs2;
        logic [31:0]           m_data;
        logic [31:0]           w_data;
        ex_pipe_pkg::fwd_sel_t fwd1;
        ex_pipe_pkg::fwd_sel_t fwd2;
        logic                  flush;
        logic                  check_alu;
    } stim_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    logic [31:0]           instr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  stall;
    logic                  flush;
    ex_pipe_pkg::fwd_sel_t fwd_rs1;
    ex_pipe_pkg::fwd_sel_t fwd_rs2;
    logic [XLEN-1:0]       m_data;
    logic [XLEN-1:0]       w_data;
    ex_pipe_pkg::ex_mem_t  result;

    string                names[$];
    stim_t                stims[$];
    ex_pipe_pkg::ex_mem_t expects[$];
    string                prev_name;
    ex_pipe_pkg::ex_mem_t prev_exp;
    logic                 prev_alu;
    logic [7:0]           lfsr_state;
    int                   limit_cycles;
    logic                 loaded = 1'b0;

    ex_subsystem #(
        .XLEN (XLEN)
    ) u_ex_subsystem (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .stall    (stall),
        .flush    (flush),
        .fwd_rs1  (fwd_rs1),
        .fwd_rs2  (fwd_rs2),
        .m_data   (m_data),
        .w_data   (w_data),
        .result   (result)
    );

    always #2 clk = ~clk;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_random_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    function automatic string format_result(input ex_pipe_pkg::ex_mem_t r);
        return {$sformatf("valid=%0b take=%0b target=%h alu_out=%h mem_data=%h pc_inc=%h",
                          r.valid, r.take_branch, r.target, r.alu_out, r.mem_data, r.pc_inc),
                $sformatf(" store=%0b writes_rd=%0b rd=%0d", r.is_store, r.writes_rd, r.rd)};
    endfunction

    task automatic check_result(input string name, input ex_pipe_pkg::ex_mem_t exp,
                                input ex_pipe_pkg::ex_mem_t act, input logic check_alu);
        logic same;
        same = (act.valid === exp.valid) && (act.take_branch === exp.take_branch) &&
               (act.target === exp.target) && (act.mem_data === exp.mem_data) &&
               (act.pc_inc === exp.pc_inc) && (!check_alu || act.alu_out === exp.alu_out) &&
               (act.is_store === exp.is_store) && (act.writes_rd === exp.writes_rd) &&
               (!exp.writes_rd || act.rd === exp.rd);
        if (!same) begin
            $display("ERROR %s: expected %s, actual %s", name, format_result(exp),
                     format_result(act));
            abort_run();
        end
    endtask

    // bubbles only promise valid, take_branch and target
    task automatic check_valid(input string name, input ex_pipe_pkg::ex_mem_t exp,
                               input ex_pipe_pkg::ex_mem_t act);
        if (act.valid !== exp.valid || act.take_branch !== exp.take_branch ||
            act.target !== exp.target) begin
            $display("ERROR %s: expected valid=%0b take=%0b target=%h, actual %s", name,
                     exp.valid, exp.take_branch, exp.target, format_result(act));
            abort_run();
        end
    endtask

    task automatic check_test(input string name, input ex_pipe_pkg::ex_mem_t exp,
                              input logic check_alu);
        if (exp.valid) begin
            check_result(name, exp, result, check_alu);
        end else begin
            check_valid(name, exp, result);
        end
    endtask

    task automatic parse_fwd(input string s, output ex_pipe_pkg::fwd_sel_t f);
        f = ex_pipe_pkg::FWD_REG;
        if (s == "mem") begin
            f = ex_pipe_pkg::FWD_MEM;
        end else if (s == "wb") begin
            f = ex_pipe_pkg::FWD_WB;
        end else if (s != "reg") begin
            $display("unknown forward source '%s' in the test file", s);
            abort_run();
        end
    endtask

    task automatic load_tests();
        int                   fd;
        int                   count;
        string                line;
        string                name;
        string                f1;
        string                f2;
        string                alu_tok;
        logic [31:0]          v[13];
        logic [6:0]           op;
        stim_t                s;
        ex_pipe_pkg::ex_mem_t e;
        fd = $fopen("tb/ex_subsystem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/ex_subsystem_tests.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            if (count > 1 && line.substr(0, 0) != "#") begin
                count = $sscanf(line, "%s %h %h %h %h %s %s %h %h %h %h %h %h %s %h %h",
                                name, v[0], v[1], v[2], v[3], f1, f2, v[4], v[5], v[6],
                                v[7], v[8], v[9], alu_tok, v[10], v[11]);
                if (count != 16) begin
                    $display("malformed line in the test file: %s", line);
                    abort_run();
                end
                s = '0;
                e = '0;
                s.instr = v[0];
                s.pc = v[1];
                s.rs1 = v[2];
                s.rs2 = v[3];
                parse_fwd(f1, s.fwd1);
                parse_fwd(f2, s.fwd2);
                s.m_data = v[4];
                s.w_data = v[5];
                s.flush = v[6][0];
                e.valid = v[7][0];
                e.take_branch = v[8][0];
                e.target = v[9];
                e.mem_data = v[10];
                e.pc_inc = v[11];
                // every opcode in scope but stores and branches writes rd
                op = v[0][6:0];
                e.is_store = e.valid && op == rv_isa_pkg::STORE;
                e.writes_rd = e.valid && op != rv_isa_pkg::STORE && op != rv_isa_pkg::BRANCH;
                e.rd = e.writes_rd ? v[0][11:7] : 5'd0;
                s.check_alu = (alu_tok != "-");
                if (s.check_alu) begin
                    count = $sscanf(alu_tok, "%h", v[12]);
                    e.alu_out = v[12];
                end
                names.push_back(name);
                stims.push_back(s);
                expects.push_back(e);
            end
        end
        $fclose(fd);
        if (names.size() == 0) begin
            $display("the test file holds no tests");
            abort_run();
        end
    endtask

    // previous result is checked, and held through any stall, while this one enters
    task automatic run_test(input int i);
        stim_t      s;
        logic       pick;
        logic [1:0] len;
        int         n;
        s = stims[i];
        n = 0;
        take_random_bit(pick);
        if (pick) begin
            take_random_bit(len[1]);
            take_random_bit(len[0]);
            n = (len == 2'd0) ? 1 : int'(len);
        end
        @(posedge clk);
        in_valid <= 1'b1;
        instr <= s.instr;
        pc <= s.pc;
        rs1_data <= s.rs1;
        rs2_data <= s.rs2;
        flush <= s.flush;
        stall <= (n != 0);
        @(negedge clk);
        check_test(prev_name, prev_exp, prev_alu);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            if (k == n - 1) begin
                stall <= 1'b0;
            end
            @(negedge clk);
            check_test({prev_name, "_held"}, prev_exp, prev_alu);
        end
        // now in EX
        @(posedge clk);
        in_valid <= 1'b0;
        flush <= 1'b0;
        fwd_rs1 <= s.fwd1;
        fwd_rs2 <= s.fwd2;
        m_data <= s.m_data;
        w_data <= s.w_data;
        prev_name = names[i];
        prev_exp = expects[i];
        prev_alu = s.check_alu;
        // EX held a bubble while this one waited in ID
        @(negedge clk);
        check_test({names[i], "_gap"}, '0, 1'b0);
    endtask

    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
        abort_run();
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        stall = 1'b0;
        flush = 1'b0;
        fwd_rs1 = ex_pipe_pkg::FWD_REG;
        fwd_rs2 = ex_pipe_pkg::FWD_REG;
        m_data = '0;
        w_data = '0;
        lfsr_state = 8'd68;
        load_tests();
        limit_cycles = names.size() * 8 + 50;
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        prev_name = "reset";
        prev_exp = '0;
        prev_alu = 1'b0;
        check_test(prev_name, prev_exp, prev_alu);
        foreach (names[i]) begin
            run_test(i);
        end
        @(posedge clk);
        @(negedge clk);
        check_test(prev_name, prev_exp, prev_alu);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== tb/ex_subsystem_tests.txt ====
# name instr pc rs1 rs2 fwd_rs1 fwd_rs2 m_data w_data flush valid take target alu_out mem_data pc_inc
# all values hex; fwd is reg, mem or wb; alu_out - is not checked
add 002082b3 100 5 7 reg reg 0 0 0 1 0 0 c 7 104
sra 4020d2b3 104 80000010 24 reg reg 0 0 0 1 0 0 f8000001 24 108
slli 00309293 108 11 0 reg reg 0 0 0 1 0 0 88 0 10c
slt 0020a2b3 10c ffffffff 1 reg reg 0 0 0 1 0 0 1 1 110
sltu 0020b2b3 110 ffffffff 1 reg reg 0 0 0 1 0 0 0 1 114
xori fff0c293 114 0f0f0000 0 reg reg 0 0 0 1 0 0 f0f0ffff 0 118
lui 123452b7 118 0 0 reg reg 0 0 0 1 0 0 12345000 0 11c
auipc 00001297 200 0 0 reg reg 0 0 0 1 0 0 1200 0 204
sub_fwd 402082b3 204 5 7 mem wb 100 20 0 1 0 0 e0 20 208
sw_fwd 0020a423 208 1000 1 wb mem cafef00d 2000 0 1 0 0 2008 cafef00d 20c
lw ffc0a283 20c 1000 0 reg reg 0 0 0 1 0 0 ffc 0 210
beq_t_fwd 00208863 300 0 55 wb reg 0 55 0 1 1 310 - 55 304
beq_n 00208863 304 55 56 reg reg 0 0 0 1 0 0 - 56 308
bne_t_back fe209ce3 320 1 2 reg reg 0 0 0 1 1 318 - 2 324
bne_n fe209ce3 324 7 7 reg reg 0 0 0 1 0 0 - 7 328
blt_t 0020c863 340 80000000 1 reg reg 0 0 0 1 1 350 - 1 344
blt_n 0020c863 344 1 80000000 reg reg 0 0 0 1 0 0 - 80000000 348
bge_t 0020d863 360 1 80000000 reg reg 0 0 0 1 1 370 - 80000000 364
bge_n 0020d863 364 80000000 1 reg reg 0 0 0 1 0 0 - 1 368
bltu_t 0020e863 380 1 80000000 reg reg 0 0 0 1 1 390 - 80000000 384
bltu_eq 0020e863 384 10 10 reg reg 0 0 0 1 0 0 - 10 388
bgeu_t 0020f863 3a0 ffffffff 1 reg reg 0 0 0 1 1 3b0 - 1 3a4
bgeu_n 0020f863 3a4 1 ffffffff reg reg 0 0 0 1 0 0 - ffffffff 3a8
jal 001000ef 400 0 0 reg reg 0 0 0 1 1 c00 404 0 404
jalr_fwd 006280e7 500 1001 0 mem reg 2001 0 0 1 1 2006 504 0 504
mul_illegal 022082b3 600 5 7 reg reg 0 0 0 0 0 0 - 0 0
add_flushed 002082b3 604 5 7 reg reg 0 0 1 0 0 0 - 0 0

// ==== ex_subsystem.f ====
src/rv_isa_pkg.sv
src/ex_pipe_pkg.sv
src/alu.sv
src/pipe_reg.sv
src/id_decode.sv
src/execute.sv
src/ex_subsystem.sv
tb/ex_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ex_subsystem_tb -Mdir obj_dir -f ex_subsystem.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vex_subsystem_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
